/* Bender.yml */
package:
  name: reorder_buffer

export_include_dirs:
  - .

sources:
  - rob_cfg_pkg.sv
  - rob_data_pkg.sv
  - rob_field_ram.sv
  - rob_status_bits.sv
  - rob_pointer_ctrl.sv
  - rob_commit_stage.sv
  - rob_top.sv
  - target: simulation
    files:
      - rob_tb.sv

/* reorder_buffer.f */
+incdir+.
rob_cfg_pkg.sv
rob_data_pkg.sv
rob_field_ram.sv
rob_status_bits.sv
rob_pointer_ctrl.sv
rob_commit_stage.sv
rob_top.sv
rob_tb.sv

/* rob_cfg_pkg.sv */
/*
 * Types that describe the shape of the buffer itself:
 * an entry position, an occupancy count and a per-entry mask.
 * Referenced by scoped name from the control modules.
 */

`include "rob_consts.svh"

package rob_cfg_pkg;

    // ==============================
    // geometry types
    // ==============================

    // position of one entry, wraps modulo depth
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // occupancy or free space, 0 up to depth inclusive
    typedef logic [`ROB_CNT_W-1:0] rob_count_t;

    // one bit per entry
    typedef logic [`ROB_DEPTH-1:0] rob_mask_t;

endpackage

/* rob_commit_stage.sv */
/*
 * Retirement of the head entry and the registered commit port.
 * The head retires once it is done, unless a mispredict is being
 * handled in the same cycle. The retired entry shows up on the
 * commit outputs one cycle later with a single-cycle valid pulse.
 */
`timescale 1ns/1ps

module rob_commit_stage (
    input  logic                     clock,
    input  logic                     reset,

    input  logic                     head_done_i,
    input  logic                     mispredict_i,
    input  rob_cfg_pkg::rob_idx_t    head_i,
    input  rob_data_pkg::dest_info_t dest_i,
    input  rob_data_pkg::word_t      value_i,

    output logic                     retire_o,

    output logic                     commit_valid_o,
    output rob_cfg_pkg::rob_idx_t    commit_rob_idx_o,
    output logic                     commit_rd_wen_o,
    output rob_data_pkg::arch_reg_t  commit_rd_arch_o,
    output rob_data_pkg::phys_reg_t  commit_new_prf_o,
    output rob_data_pkg::phys_reg_t  commit_old_prf_o,
    output rob_data_pkg::word_t      commit_value_o
);

    // mispredict freezes retirement for one cycle
    assign retire_o = head_done_i && !mispredict_i;

    // ==============================
    // commit registers
    // ==============================

    // valid pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_o;
        end
    end

    // payload, only meaningful alongside the pulse
    always_ff @(posedge clock) begin
        if (retire_o) begin
            commit_rob_idx_o <= head_i;
            commit_rd_wen_o  <= dest_i.rd_wen;
            commit_rd_arch_o <= dest_i.rd_arch;
            commit_new_prf_o <= dest_i.new_prf;
            commit_old_prf_o <= dest_i.old_prf;
            commit_value_o   <= value_i;
        end
    end

endmodule

/* rob_consts.svh */
/*
 * Shared sizing constants for the reorder buffer.
 * Included by the two packages and by every module that sizes
 * ports or arrays. The buffer geometry and the data widths are
 * fixed here and used everywhere else.
 */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// ==============================
// buffer geometry
// ==============================

// entries in the buffer, power of two
`define ROB_DEPTH 16
// log2 of depth
`define ROB_IDX_W 4
// one bit more, so a full buffer fits
`define ROB_CNT_W 5

// ==============================
// register and data widths
// ==============================

`define ARCH_REG_W 5
`define PHYS_REG_W 6
`define XLEN 32

// functional-unit result ports
`define WB_PORTS 2

`endif

/* rob_data_pkg.sv */
/*
 * Types for the payload carried through the buffer:
 * register numbers, the result word and the destination record
 * written at dispatch and handed out again at commit.
 */

`include "rob_consts.svh"

package rob_data_pkg;

    // ==============================
    // register numbers
    // ==============================

    typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [`PHYS_REG_W-1:0] phys_reg_t;

    // result value from a functional unit
    typedef logic [`XLEN-1:0] word_t;

    // ==============================
    // destination record
    // ==============================

    // filled at dispatch, read back at commit
    // old_prf goes back to the free list on retirement
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } dest_info_t;

endpackage

/* rob_field_ram.sv */
/*
 * Per-entry payload storage for the reorder buffer.
 * One word of payload_t per entry, written by NUM_WR_PORTS
 * ports and read combinationally at one index (the head).
 * Used once for the destination record and once for results.
 */
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_field_ram #(
    parameter type         payload_t    = logic,
    parameter int unsigned NUM_WR_PORTS = 1,
    parameter int unsigned DEPTH        = `ROB_DEPTH
) (
    input  logic                  clock,
    input  logic                  reset,

    // write side
    input  logic [NUM_WR_PORTS-1:0] wr_en_i,
    input  rob_cfg_pkg::rob_idx_t wr_idx_i  [NUM_WR_PORTS],
    input  payload_t              wr_data_i [NUM_WR_PORTS],

    // read side
    input  rob_cfg_pkg::rob_idx_t rd_idx_i,
    output payload_t              rd_data_o
);

    // storage, contents undefined until first write
    payload_t mem_q [DEPTH];

    // ==============================
    // write ports
    // ==============================

    // ports never target the same entry in one cycle
    // writes held off while in reset
    always_ff @(posedge clock) begin
        for (int p = 0; p < NUM_WR_PORTS; p++) begin
            if (!reset && wr_en_i[p]) begin
                mem_q[wr_idx_i[p]] <= wr_data_i[p];
            end
        end
    end

    // ==============================
    // read port
    // ==============================

    // combinational, data written on edge N visible right after it
    assign rd_data_o = mem_q[rd_idx_i];

endmodule

/* rob_pointer_ctrl.sv */
/*
 * Head, tail and occupancy of the reorder buffer.
 * Makes the dispatch handshake: ready when not full and no
 * mispredict this cycle, alloc when valid meets ready.
 * On a mispredict the tail moves to just behind the named entry
 * and the count is rebuilt from the head distance.
 */
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_pointer_ctrl (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    disp_valid_i,
    input  logic                    retire_i,

    input  logic                    mispredict_i,
    input  rob_cfg_pkg::rob_idx_t   mispredict_rob_idx_i,

    output logic                    alloc_o,
    output logic                    disp_ready_o,
    output rob_cfg_pkg::rob_idx_t   head_o,
    output rob_cfg_pkg::rob_idx_t   tail_o,
    output rob_cfg_pkg::rob_count_t disp_space_o
);

    rob_cfg_pkg::rob_idx_t   head_q;
    rob_cfg_pkg::rob_idx_t   tail_q;
    rob_cfg_pkg::rob_count_t count_q;
    rob_cfg_pkg::rob_idx_t   keep_dist;
    logic                    full;

    // ==============================
    // handshake
    // ==============================

    assign full         = (count_q == `ROB_DEPTH);
    assign disp_ready_o = !full && !mispredict_i;
    assign alloc_o      = disp_valid_i && disp_ready_o;

    // free entries for the dispatch stage
    assign disp_space_o = rob_cfg_pkg::rob_count_t'(`ROB_DEPTH) - count_q;

    // head to named entry, the named one itself added below
    assign keep_dist = mispredict_rob_idx_i - head_q;

    // ==============================
    // pointer update
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (mispredict_i) begin
            // no alloc, no retire in this cycle
            tail_q  <= mispredict_rob_idx_i + 1'b1;
            count_q <= {1'b0, keep_dist} + 1'b1;
        end else begin
            // pointers wrap by natural overflow
            if (alloc_o) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_i) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q
                     + rob_cfg_pkg::rob_count_t'(alloc_o)
                     - rob_cfg_pkg::rob_count_t'(retire_i);
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

/* rob_status_bits.sv */
/*
 * Valid and done flags for every buffer entry.
 * valid is set at allocation and cleared at retirement or when a
 * mispredict discards the entry. done is cleared at allocation
 * and set by writeback. head_done_o tells the commit stage that
 * the oldest entry can retire.
 */
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_status_bits (
    input  logic                  clock,
    input  logic                  reset,

    // allocation at the tail
    input  logic                  alloc_i,
    input  rob_cfg_pkg::rob_idx_t tail_i,

    // writeback
    input  logic [`WB_PORTS-1:0]  wb_valid_i,
    input  rob_cfg_pkg::rob_idx_t wb_rob_idx_i [`WB_PORTS],

    // retirement at the head
    input  logic                  retire_i,
    input  rob_cfg_pkg::rob_idx_t head_i,

    // rollback
    input  logic                  mispredict_i,
    input  rob_cfg_pkg::rob_idx_t mispredict_rob_idx_i,

    output logic                  head_done_o
);

    rob_cfg_pkg::rob_mask_t valid_q;
    rob_cfg_pkg::rob_mask_t done_q;
    rob_cfg_pkg::rob_mask_t valid_d;
    rob_cfg_pkg::rob_mask_t done_d;
    rob_cfg_pkg::rob_mask_t discard;

    // ==============================
    // discard mask
    // ==============================

    // entries after the named one, up to but not incl. the tail
    // measured as distance from named+1, so wrap needs no special case
    always_comb begin
        rob_cfg_pkg::rob_idx_t span;
        rob_cfg_pkg::rob_idx_t rel;
        span = tail_i - mispredict_rob_idx_i - 1'b1;
        discard = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rel = rob_cfg_pkg::rob_idx_t'(i) - mispredict_rob_idx_i - 1'b1;
            discard[i] = (rel < span);
        end
    end

    // ==============================
    // next state
    // ==============================

    always_comb begin
        valid_d = valid_q;
        done_d  = done_q;

        // writeback runs in every cycle, mispredict included
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_valid_i[p]) begin
                done_d[wb_rob_idx_i[p]] = 1'b1;
            end
        end

        // alloc and retire never coincide with a mispredict
        if (alloc_i) begin
            valid_d[tail_i] = 1'b1;
            done_d[tail_i]  = 1'b0;
        end
        if (retire_i) begin
            valid_d[head_i] = 1'b0;
        end
        if (mispredict_i) begin
            valid_d = valid_d & ~discard;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            valid_q <= valid_d;
            done_q  <= done_d;
        end
    end

    // oldest entry has its result
    assign head_done_o = valid_q[head_i] & done_q[head_i];

endmodule

/* rob_tb.sv */
/*
 * Self-checking random testbench for the reorder buffer.
 * An in-order queue model predicts dispatch indices, ready, free
 * space and every commit. Stimulus comes from $random with a fixed
 * seed. After the random phase the buffer is drained and checked empty.
 */
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 100;

    // one model entry
    // oldest sits at the front of the queue
    typedef struct packed {
        rob_cfg_pkg::rob_idx_t    idx;
        rob_data_pkg::dest_info_t dest;
        logic                     done;
        rob_data_pkg::word_t      value;
    } entry_t;

    logic                     clock;
    logic                     reset;
    logic                     disp_valid;
    logic                     disp_rd_wen;
    rob_data_pkg::arch_reg_t  disp_rd_arch;
    rob_data_pkg::phys_reg_t  disp_rd_new_prf;
    rob_data_pkg::phys_reg_t  disp_rd_old_prf;
    logic                     disp_ready;
    rob_cfg_pkg::rob_idx_t    disp_rob_idx;
    rob_cfg_pkg::rob_count_t  disp_space;
    logic [`WB_PORTS-1:0]     wb_valid;
    rob_cfg_pkg::rob_idx_t    wb_rob_idx [`WB_PORTS];
    rob_data_pkg::word_t      wb_value   [`WB_PORTS];
    logic                     mispredict;
    rob_cfg_pkg::rob_idx_t    mispredict_rob_idx;
    logic                     commit_valid;
    rob_cfg_pkg::rob_idx_t    commit_rob_idx;
    logic                     commit_rd_wen;
    rob_data_pkg::arch_reg_t  commit_rd_arch;
    rob_data_pkg::phys_reg_t  commit_new_prf;
    rob_data_pkg::phys_reg_t  commit_old_prf;
    rob_data_pkg::word_t      commit_value;

    // ==============================
    // model state
    // ==============================

    entry_t                model_q [$];
    rob_cfg_pkg::rob_idx_t next_idx;
    entry_t                exp_commit;
    logic                  exp_commit_valid;
    integer                seed;
    int                    commit_count;

    rob_top rob_top_inst (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid),
        .disp_rd_wen_i        (disp_rd_wen),
        .disp_rd_arch_i       (disp_rd_arch),
        .disp_rd_new_prf_i    (disp_rd_new_prf),
        .disp_rd_old_prf_i    (disp_rd_old_prf),
        .disp_ready_o         (disp_ready),
        .disp_rob_idx_o       (disp_rob_idx),
        .disp_space_o         (disp_space),
        .wb_valid_i           (wb_valid),
        .wb_rob_idx_i         (wb_rob_idx),
        .wb_value_i           (wb_value),
        .mispredict_i         (mispredict),
        .mispredict_rob_idx_i (mispredict_rob_idx),
        .commit_valid_o       (commit_valid),
        .commit_rob_idx_o     (commit_rob_idx),
        .commit_rd_wen_o      (commit_rd_wen),
        .commit_rd_arch_o     (commit_rd_arch),
        .commit_new_prf_o     (commit_new_prf),
        .commit_old_prf_o     (commit_old_prf),
        .commit_value_o       (commit_value)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // commit pulse from the last edge against the model's oldest entry
    task automatic check_commit();
        check_value("commit_valid_o", exp_commit_valid, commit_valid);
        if (exp_commit_valid) begin
            check_value("commit_rob_idx_o", exp_commit.idx, commit_rob_idx);
            check_value("commit_rd_wen_o", exp_commit.dest.rd_wen, commit_rd_wen);
            check_value("commit_rd_arch_o", exp_commit.dest.rd_arch, commit_rd_arch);
            check_value("commit_new_prf_o", exp_commit.dest.new_prf, commit_new_prf);
            check_value("commit_old_prf_o", exp_commit.dest.old_prf, commit_old_prf);
            check_value("commit_value_o", exp_commit.value, commit_value);
            commit_count++;
        end
    endtask

    // ==============================
    // one clock cycle
    // ==============================

    // entered 1 ns after a rising edge and left 1 ns after the next one
    task automatic run_cycle(input bit draining);
        entry_t e;
        int     cand [$];
        int     wb_pos [`WB_PORTS];
        int     pick;
        int     keep_pos;
        bit     exp_ready;
        bit     retire;
        check_commit();
        check_value("disp_space_o", `ROB_DEPTH - model_q.size(), disp_space);

        // dispatch in about 70% of cycles and never while draining
        disp_valid      = !draining && (rand_below(100) < 70);
        disp_rd_wen     = rand_below(2);
        disp_rd_arch    = rand_below(32);
        disp_rd_new_prf = rand_below(64);
        disp_rd_old_prf = rand_below(64);

        // rare mispredict on a live entry
        keep_pos   = model_q.size() - 1;
        mispredict = 1'b0;
        if (!draining && model_q.size() > 0 && rand_below(100) < 3) begin
            keep_pos           = rand_below(model_q.size());
            mispredict         = 1'b1;
            mispredict_rob_idx = model_q[keep_pos].idx;
        end

        // writebacks only to pending survivors and to distinct entries per port
        for (int i = 0; i <= keep_pos; i++) begin
            if (!model_q[i].done) begin
                cand.push_back(i);
            end
        end
        wb_valid = '0;
        for (int p = 0; p < `WB_PORTS; p++) begin
            wb_pos[p] = 0;
            if (cand.size() > 0 && (draining || rand_below(100) < 60)) begin
                pick          = rand_below(cand.size());
                wb_pos[p]     = cand[pick];
                wb_valid[p]   = 1'b1;
                wb_rob_idx[p] = model_q[cand[pick]].idx;
                wb_value[p]   = $random(seed);
                cand.delete(pick);
            end
        end

        #1;
        exp_ready = (model_q.size() < `ROB_DEPTH) && !mispredict;
        check_value("disp_ready_o", exp_ready, disp_ready);
        if (disp_valid && exp_ready) begin
            check_value("disp_rob_idx_o", next_idx, disp_rob_idx);
        end

        // head retires only if done before this edge
        retire           = !mispredict && model_q.size() > 0 && model_q[0].done;
        exp_commit_valid = retire;
        if (retire) begin
            exp_commit = model_q[0];
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_valid[p]) begin
                e       = model_q[wb_pos[p]];
                e.done  = 1'b1;
                e.value = wb_value[p];
                model_q[wb_pos[p]] = e;
            end
        end
        // rollback drops everything younger than the named entry
        if (mispredict) begin
            while (model_q.size() > keep_pos + 1) begin
                void'(model_q.pop_back());
            end
            next_idx = mispredict_rob_idx + 1'b1;
        end
        if (retire) begin
            void'(model_q.pop_front());
        end
        if (disp_valid && exp_ready) begin
            e.idx          = next_idx;
            e.dest.rd_wen  = disp_rd_wen;
            e.dest.rd_arch = disp_rd_arch;
            e.dest.new_prf = disp_rd_new_prf;
            e.dest.old_prf = disp_rd_old_prf;
            e.done         = 1'b0;
            e.value        = '0;
            model_q.push_back(e);
            next_idx = next_idx + 1'b1;
        end

        @(posedge clock);
        #1;
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        int drain_cycles;
        seed               = 55122;
        commit_count       = 0;
        next_idx           = '0;
        exp_commit_valid   = 1'b0;
        reset              = 1'b1;
        disp_valid         = 1'b0;
        disp_rd_wen        = 1'b0;
        disp_rd_arch       = '0;
        disp_rd_new_prf    = '0;
        disp_rd_old_prf    = '0;
        wb_valid           = '0;
        mispredict         = 1'b0;
        mispredict_rob_idx = '0;
        for (int p = 0; p < `WB_PORTS; p++) begin
            wb_rob_idx[p] = '0;
            wb_value[p]   = '0;
        end

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(1'b0);
        end

        // drain and then one more cycle for the last commit pulse
        drain_cycles = 0;
        while (model_q.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
            run_cycle(1'b1);
            drain_cycles++;
        end
        run_cycle(1'b1);
        if (model_q.size() != 0) begin
            $display("buffer still holds %0d entries after the drain", model_q.size());
            $display("Testbench failed");
            $fatal(1, "drain did not complete");
        end
        check_value("disp_space_o", `ROB_DEPTH, disp_space);

        $display("%0d entries committed", commit_count);
        $display("Testbench passed");
        $finish;
    end

    // run length plus drain plus a small margin
    initial begin
        #((NUM_CYCLES + DRAIN_LIMIT + 20) * CLK_PERIOD);
        $display("simulation ran past its time limit without finishing");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* rob_top.sv */
/*
 * Reorder buffer top level.
 * In-order dispatch with a valid/ready handshake, out-of-order
 * writeback on two result ports, in-order commit of one entry
 * per cycle and rollback on a branch mispredict.
 * Only instances and the wires between them live here.
 */
`timescale 1ns/1ps

`include "rob_consts.svh"

module rob_top (
    input  logic                      clock,
    input  logic                      reset,

    // dispatch
    input  logic                      disp_valid_i,
    input  logic                      disp_rd_wen_i,
    input  rob_data_pkg::arch_reg_t   disp_rd_arch_i,
    input  rob_data_pkg::phys_reg_t   disp_rd_new_prf_i,
    input  rob_data_pkg::phys_reg_t   disp_rd_old_prf_i,
    output logic                      disp_ready_o,
    output rob_cfg_pkg::rob_idx_t     disp_rob_idx_o,
    output rob_cfg_pkg::rob_count_t   disp_space_o,

    // writeback
    input  logic [`WB_PORTS-1:0]      wb_valid_i,
    input  rob_cfg_pkg::rob_idx_t     wb_rob_idx_i [`WB_PORTS],
    input  rob_data_pkg::word_t       wb_value_i   [`WB_PORTS],

    // branch rollback
    input  logic                      mispredict_i,
    input  rob_cfg_pkg::rob_idx_t     mispredict_rob_idx_i,

    // commit
    output logic                      commit_valid_o,
    output rob_cfg_pkg::rob_idx_t     commit_rob_idx_o,
    output logic                      commit_rd_wen_o,
    output rob_data_pkg::arch_reg_t   commit_rd_arch_o,
    output rob_data_pkg::phys_reg_t   commit_new_prf_o,
    output rob_data_pkg::phys_reg_t   commit_old_prf_o,
    output rob_data_pkg::word_t       commit_value_o
);

    logic                     alloc;
    logic                     retire;
    logic                     head_done;
    rob_cfg_pkg::rob_idx_t    head;
    rob_cfg_pkg::rob_idx_t    tail;
    rob_data_pkg::dest_info_t head_dest;
    rob_data_pkg::word_t      head_value;

    // single write port of the destination store
    rob_cfg_pkg::rob_idx_t    dest_wr_idx  [1];
    rob_data_pkg::dest_info_t dest_wr_data [1];

    assign disp_rob_idx_o  = tail;
    assign dest_wr_idx[0]  = tail;
    assign dest_wr_data[0] = '{rd_wen:  disp_rd_wen_i,
                               rd_arch: disp_rd_arch_i,
                               new_prf: disp_rd_new_prf_i,
                               old_prf: disp_rd_old_prf_i};

    // ==============================
    // control
    // ==============================

    rob_pointer_ctrl rob_pointer_ctrl_inst (
        .clock                (clock),
        .reset                (reset),
        .disp_valid_i         (disp_valid_i),
        .retire_i             (retire),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .alloc_o              (alloc),
        .disp_ready_o         (disp_ready_o),
        .head_o               (head),
        .tail_o               (tail),
        .disp_space_o         (disp_space_o)
    );

    rob_status_bits rob_status_bits_inst (
        .clock                (clock),
        .reset                (reset),
        .alloc_i              (alloc),
        .tail_i               (tail),
        .wb_valid_i           (wb_valid_i),
        .wb_rob_idx_i         (wb_rob_idx_i),
        .retire_i             (retire),
        .head_i               (head),
        .mispredict_i         (mispredict_i),
        .mispredict_rob_idx_i (mispredict_rob_idx_i),
        .head_done_o          (head_done)
    );

    rob_commit_stage rob_commit_stage_inst (
        .clock            (clock),
        .reset            (reset),
        .head_done_i      (head_done),
        .mispredict_i     (mispredict_i),
        .head_i           (head),
        .dest_i           (head_dest),
        .value_i          (head_value),
        .retire_o         (retire),
        .commit_valid_o   (commit_valid_o),
        .commit_rob_idx_o (commit_rob_idx_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o),
        .commit_value_o   (commit_value_o)
    );

    // ==============================
    // payload storage
    // ==============================

    // destination record, written at the tail on dispatch
    rob_field_ram #(
        .payload_t    (rob_data_pkg::dest_info_t),
        .NUM_WR_PORTS (1),
        .DEPTH        (`ROB_DEPTH)
    ) dest_ram_inst (
        .clock     (clock),
        .reset     (reset),
        .wr_en_i   (alloc),
        .wr_idx_i  (dest_wr_idx),
        .wr_data_i (dest_wr_data),
        .rd_idx_i  (head),
        .rd_data_o (head_dest)
    );

    // result values, written by the functional units
    rob_field_ram #(
        .payload_t    (rob_data_pkg::word_t),
        .NUM_WR_PORTS (`WB_PORTS),
        .DEPTH        (`ROB_DEPTH)
    ) value_ram_inst (
        .clock     (clock),
        .reset     (reset),
        .wr_en_i   (wb_valid_i),
        .wr_idx_i  (wb_rob_idx_i),
        .wr_data_i (wb_value_i),
        .rd_idx_i  (head),
        .rd_data_o (head_value)
    );

endmodule
